// ==== files.f ====
design/icache_pkg.sv
design/cache_array.sv
design/fill_counter.sv
design/line_accumulator.sv
design/icache_controller.sv
design/icache.sv
test/icache_asserts.sv
test/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - design/icache_pkg.sv
      - design/cache_array.sv
      - design/fill_counter.sv
      - design/line_accumulator.sv
      - design/icache_controller.sv
      - design/icache.sv
  - target: test
    files:
      - test/icache_asserts.sv
      - test/icache_tb.sv

// ==== test/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    // Requests issued, counting reset and the TLB stall attempt
    localparam int NUM_REQUESTS = 13;
    localparam int TIMEOUT      = 40 * NUM_REQUESTS + 200;

    localparam logic [31:0] ADDR_A  = 32'h0000_1040;
    localparam logic [31:0] ADDR_B  = 32'h0000_2080;
    localparam logic [31:0] ADDR_C1 = 32'h0000_3100;
    localparam logic [31:0] ADDR_C2 = 32'h0000_7100;
    localparam logic [31:0] ADDR_D  = 32'h0000_50c0;
    localparam logic [31:0] ADDR_E  = 32'h0000_6160;

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic              req_ready;
    logic [ADDR_W-1:0] req_address;
    logic              dp_valid;
    logic              dp_ready;
    line_t             dp_read_data;
    logic [ADDR_W-1:0] phys_addr;
    logic              tlb_hit;
    logic              tlb_pcd;
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_req;
    logic              mem_data_valid;
    logic [BUS_W-1:0]  mem_data;
    logic              mem_rd_wr;
    logic              mem_en;
    logic              grant_in;
    logic              grant_out;
    logic              bus_busy_out;
    logic              bus_busy_in;
    int                errors;
    int                cycle_count;

    icache #(.DEPTH(NUM_SETS)) icache_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Memory contents as seen on the bus
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic ring(input logic grant, input logic busy);
        grant_in    <= grant;
        bus_busy_in <= busy;
    endtask

    // Returns one beat per bus word, 0 to 2 idle cycles apart
    task automatic memory_model();
        int          gap;
        logic [31:0] addr;
        gap = 0;
        forever begin
            @(posedge clk);
            addr = mem_addr;
            if (mem_data_valid) begin
                // Beat taken at this edge, address moves on
                addr = mem_addr + 32'd4;
                gap  = $urandom_range(2, 0);
            end
            if (mem_req && gap == 0) begin
                mem_data_valid <= 1'b1;
                mem_data       <= mem_word(addr);
            end else begin
                mem_data_valid <= 1'b0;
                if (gap > 0) begin
                    gap--;
                end
            end
        end
    endtask

    task automatic fetch(input string name, input logic [31:0] addr, input logic pcd,
                         input bit expect_miss, input int stall);
        line_t       expected;
        line_t       held;
        logic [31:0] base;
        logic [31:0] beats [$];
        int          latency;
        bit          saw_req;
        base = {addr[31:4], 4'h0};
        for (int k = 0; k < FILL_BEATS; k++) begin
            expected[k*BUS_W +: BUS_W] = mem_word(base + 32'(4 * k));
        end
        dp_ready    <= (stall == 0);
        req_valid   <= 1'b1;
        req_address <= addr;
        phys_addr   <= addr;
        tlb_pcd     <= pcd;
        do begin
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
        latency = 0;
        saw_req = 1'b0;
        while (!dp_valid) begin
            @(posedge clk);
            latency++;
            if (mem_req) begin
                saw_req = 1'b1;
            end
            if (mem_data_valid && mem_en) begin
                beats.push_back(mem_addr);
            end
        end
        held = dp_read_data;
        check({name, " line"}, expected, held);
        check({name, " bus read"}, expect_miss, saw_req);
        // Bus already given back once the response is up
        check({name, " bus released"}, 0, {mem_req, mem_en, bus_busy_out});
        if (expect_miss) begin
            check({name, " beat count"}, FILL_BEATS, beats.size());
            for (int k = 0; k < beats.size() && k < FILL_BEATS; k++) begin
                check({name, " beat address"}, base + 32'(4 * k), beats[k]);
            end
        end else begin
            check({name, " hit latency"}, 2, latency);
        end
        // Hold off the response and try to sneak in another request
        for (int i = 0; i < stall; i++) begin
            req_valid <= 1'b1;
            @(posedge clk);
            check({name, " held valid"}, 1, dp_valid);
            check({name, " held line"}, held, dp_read_data);
            check({name, " ready in stall"}, 0, req_ready);
        end
        if (stall > 0) begin
            req_valid <= 1'b0;
            dp_ready  <= 1'b1;
            @(posedge clk);
        end
    endtask

    task automatic cold_miss_then_hit();
        fetch("cold miss", ADDR_A, 1'b0, 1'b1, 0);
        fetch("warm hit", ADDR_A, 1'b0, 1'b0, 0);
    endtask

    task automatic uncacheable_fetch();
        fetch("uncacheable first", ADDR_B, 1'b1, 1'b1, 0);
        fetch("uncacheable repeat", ADDR_B, 1'b1, 1'b1, 0);
    endtask

    task automatic conflict_eviction();
        fetch("conflict first", ADDR_C1, 1'b0, 1'b1, 0);
        fetch("conflict second", ADDR_C2, 1'b0, 1'b1, 0);
        fetch("conflict evicted", ADDR_C1, 1'b0, 1'b1, 0);
        fetch("other index kept", ADDR_A, 1'b0, 1'b0, 0);
    endtask

    task automatic grant_passing();
        ring(1'b0, 1'b0);
        @(posedge clk);
        check("grant idle low", 0, grant_out);
        ring(1'b1, 1'b0);
        @(posedge clk);
        check("grant idle high", 1, grant_out);
        ring(1'b1, 1'b1);
        fork
            fetch("grant busy miss", ADDR_D, 1'b0, 1'b1, 0);
            begin
                repeat (8) begin
                    @(posedge clk);
                    check("grant busy no mem_req", 0, mem_req);
                end
                ring(1'b1, 1'b0);
            end
        join
    endtask

    task automatic backpressure_and_tlb_stall();
        fetch("stall on hit", ADDR_A, 1'b0, 1'b0, $urandom_range(9, 2));
        fetch("stall on miss", ADDR_E, 1'b0, 1'b1, $urandom_range(9, 2));
        tlb_hit     <= 1'b0;
        req_valid   <= 1'b1;
        req_address <= ADDR_C2;
        phys_addr   <= ADDR_C2;
        repeat (4) begin
            @(posedge clk);
            check("tlb miss ready", 0, req_ready);
        end
        req_valid <= 1'b0;
        tlb_hit   <= 1'b1;
        @(posedge clk);
        check("tlb miss no response", 0, dp_valid);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'hbfbae28a));
        errors         = 0;
        rst            = 1'b1;
        req_valid      = 1'b0;
        req_address    = '0;
        phys_addr      = '0;
        tlb_hit        = 1'b1;
        tlb_pcd        = 1'b0;
        dp_ready       = 1'b1;
        mem_data_valid = 1'b0;
        mem_data       = '0;
        grant_in       = 1'b0;
        bus_busy_in    = 1'b0;
        fork
            memory_model();
        join_none
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        check("reset dp_valid", 0, dp_valid);
        check("reset mem_req", 0, mem_req);
        check("reset mem_en", 0, mem_en);
        check("reset bus_busy_out", 0, bus_busy_out);
        check("reset grant_out", 0, grant_out);
        check("reset req_ready", 1, req_ready);
        ring(1'b1, 1'b0);
        cold_miss_then_hit();
        uncacheable_fetch();
        grant_passing();
        conflict_eviction();
        backpressure_and_tlb_stall();
        $display("Tests done with %0d check errors and %0d assertion failures",
                 errors, icache_i.asserts_i.failures);
        if (errors == 0 && icache_i.asserts_i.failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/icache_asserts.sv ====
`timescale 1ns/1ps

module icache_asserts
    import icache_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  dp_valid,
    input logic  dp_ready,
    input line_t dp_read_data,
    input logic  mem_req,
    input logic  mem_rd_wr,
    input logic  bus_busy_out,
    input logic  grant_out,
    input logic  grant_in,
    input logic  bus_busy_in
);

    // Count of failed assertions
    int failures = 0;

    // Response held until the fetch stage takes it
    assert property (@(posedge clk) disable iff (rst)
        dp_valid && !dp_ready |=> dp_valid && $stable(dp_read_data))
        else begin
            failures++;
            $error("response dropped or changed before dp_ready");
        end

    assert property (@(posedge clk) disable iff (rst) mem_req |-> bus_busy_out)
        else begin
            failures++;
            $error("mem_req raised without holding the bus");
        end

    assert property (@(posedge clk) disable iff (rst) bus_busy_out |-> !grant_out)
        else begin
            failures++;
            $error("token passed on while the bus is held");
        end

    // Token taken only while it is free
    assert property (@(posedge clk) disable iff (rst)
        $rose(bus_busy_out) |-> $past(grant_in && !bus_busy_in))
        else begin
            failures++;
            $error("bus taken without a free token");
        end

    assert property (@(posedge clk) !mem_rd_wr)
        else begin
            failures++;
            $error("bus write issued by the instruction cache");
        end

endmodule

bind icache icache_asserts asserts_i (
    .clk(clk), .rst(rst), .dp_valid(dp_valid), .dp_ready(dp_ready),
    .dp_read_data(dp_read_data), .mem_req(mem_req), .mem_rd_wr(mem_rd_wr),
    .bus_busy_out(bus_busy_out), .grant_out(grant_out), .grant_in(grant_in),
    .bus_busy_in(bus_busy_in)
);

// ==== design/icache.sv ====
`timescale 1ns/1ps

module icache
    import icache_pkg::*;
#(
    parameter int DEPTH = NUM_SETS
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  logic [ADDR_W-1:0] req_address,
    output logic              dp_valid,
    input  logic              dp_ready,
    output line_t             dp_read_data,
    input  logic [ADDR_W-1:0] phys_addr,
    input  logic              tlb_hit,
    input  logic              tlb_pcd,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              mem_req,
    input  logic              mem_data_valid,
    input  logic [BUS_W-1:0]  mem_data,
    output logic              mem_rd_wr,
    output logic              mem_en,
    input  logic              grant_in,
    output logic              grant_out,
    output logic              bus_busy_out,
    input  logic              bus_busy_in
);

    localparam int OFF_W = ADDR_W - TAG_W - INDEX_W;

    fill_req_t          fill_q;
    logic               capture;
    logic [INDEX_W-1:0] rd_index;
    tag_entry_t         tag_rd;
    tag_entry_t         tag_wr;
    line_t              data_rd;
    line_t              acc_line;
    logic               tag_match;
    logic               line_sel;
    logic               fill_start;
    logic               array_wr;
    logic               beat_valid;
    logic [BEAT_W-1:0]  beat;
    logic               last_beat;

    // Reads only
    assign mem_rd_wr = 1'b0;

    // Request fields captured at acceptance
    always_ff @(posedge clk) begin
        if (capture) begin
            fill_q.base        <= {phys_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
            fill_q.index       <= req_address[OFF_W +: INDEX_W];
            fill_q.tag         <= phys_addr[ADDR_W-1 -: TAG_W];
            fill_q.uncacheable <= tlb_pcd;
        end
    end

    // Keep reading the held index so a hit line stays put in RESPOND
    assign rd_index = capture ? req_address[OFF_W +: INDEX_W] : fill_q.index;

    assign tag_match  = tag_rd.valid && (tag_rd.tag == fill_q.tag);
    assign tag_wr     = '{valid: 1'b1, tag: fill_q.tag};
    assign beat_valid = mem_data_valid && mem_en;

    cache_array #(.entry_t(tag_entry_t), .DEPTH(DEPTH)) tag_array (
        .clk(clk), .rst(rst), .rd_index(rd_index), .wr_en(array_wr),
        .wr_index(fill_q.index), .wr_data(tag_wr), .rd_data(tag_rd)
    );

    cache_array #(.entry_t(line_t), .DEPTH(DEPTH)) data_array (
        .clk(clk), .rst(rst), .rd_index(rd_index), .wr_en(array_wr),
        .wr_index(fill_q.index), .wr_data(acc_line), .rd_data(data_rd)
    );

    icache_controller ctrl (
        .clk(clk), .rst(rst), .req_valid(req_valid), .tlb_hit(tlb_hit),
        .uncacheable(fill_q.uncacheable), .tag_match(tag_match), .dp_ready(dp_ready),
        .grant_in(grant_in), .bus_busy_in(bus_busy_in), .beat_valid(beat_valid),
        .last_beat(last_beat), .req_ready(req_ready), .capture(capture),
        .dp_valid(dp_valid), .line_sel(line_sel), .fill_start(fill_start),
        .array_wr(array_wr), .mem_req(mem_req), .mem_en(mem_en),
        .bus_busy_out(bus_busy_out), .grant_out(grant_out)
    );

    fill_counter counter (
        .clk(clk), .rst(rst), .start(fill_start), .beat_valid(beat_valid),
        .base_addr(fill_q.base), .beat(beat), .last_beat(last_beat),
        .beat_addr(mem_addr)
    );

    line_accumulator accum (
        .clk(clk), .rst(rst), .beat_valid(beat_valid), .beat(beat),
        .beat_data(mem_data), .line(acc_line)
    );

    assign dp_read_data = line_sel ? acc_line : data_rd;

endmodule

// ==== design/icache_controller.sv ====
`timescale 1ns/1ps

module icache_controller
    import icache_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    input  logic tlb_hit,
    input  logic uncacheable,
    input  logic tag_match,
    input  logic dp_ready,
    input  logic grant_in,
    input  logic bus_busy_in,
    input  logic beat_valid,
    input  logic last_beat,
    output logic req_ready,
    output logic capture,
    output logic dp_valid,
    output logic line_sel,
    output logic fill_start,
    output logic array_wr,
    output logic mem_req,
    output logic mem_en,
    output logic bus_busy_out,
    output logic grant_out
);

    ic_state_t state;
    ic_state_t state_nxt;
    logic      hit;
    logic      fill_done;
    logic      hold_bus;

    assign hit       = tag_match && !uncacheable;
    assign fill_done = beat_valid && last_beat;

    // Fetch side handshake
    assign req_ready = (state == IDLE) && tlb_hit;
    assign capture   = req_valid && req_ready;
    assign dp_valid  = (state == RESPOND);

    // Bus levels while the token is held
    assign hold_bus     = (state == FILL);
    assign mem_req      = hold_bus;
    assign mem_en       = hold_bus;
    assign bus_busy_out = hold_bus;

    // Token passes on unless we want it or hold it
    assign grant_out = grant_in && (state != WAIT_BUS) && !hold_bus;

    assign fill_start = (state == LOOKUP) && !hit;
    assign array_wr   = (state == FILL) && fill_done && !uncacheable;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (capture) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_nxt = RESPOND;
                end else begin
                    state_nxt = WAIT_BUS;
                end
            end
            WAIT_BUS: begin
                // Take the token once nobody else is on the bus
                if (grant_in && !bus_busy_in) begin
                    state_nxt = FILL;
                end
            end
            FILL: begin
                if (fill_done) begin
                    state_nxt = RESPOND;
                end
            end
            RESPOND: begin
                if (dp_ready) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            line_sel <= 1'b0;
        end else begin
            state <= state_nxt;
            // 0 selects the data array, 1 the accumulator
            if (state == LOOKUP && hit) begin
                line_sel <= 1'b0;
            end else if (state == FILL && fill_done) begin
                line_sel <= 1'b1;
            end
        end
    end

endmodule

// ==== design/line_accumulator.sv ====
`timescale 1ns/1ps

module line_accumulator
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              beat_valid,
    input  logic [BEAT_W-1:0] beat,
    input  logic [BUS_W-1:0]  beat_data,
    output line_t             line
);

    logic [FILL_BEATS-1:0] we;
    logic [BUS_W-1:0]      word_q [FILL_BEATS];

    // Beat number to slot enable
    always_comb begin
        we = '0;
        if (beat_valid) begin
            we[beat] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FILL_BEATS; i++) begin
                word_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < FILL_BEATS; i++) begin
                if (we[i]) begin
                    word_q[i] <= beat_data;
                end
            end
        end
    end

    // Last word bypasses its register on the final beat
    always_comb begin
        for (int i = 0; i < FILL_BEATS - 1; i++) begin
            line[i*BUS_W +: BUS_W] = word_q[i];
        end
        line[LINE_W-1 -: BUS_W] = we[FILL_BEATS-1] ? beat_data : word_q[FILL_BEATS-1];
    end

endmodule

// ==== design/fill_counter.sv ====
`timescale 1ns/1ps

module fill_counter
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              beat_valid,
    input  logic [ADDR_W-1:0] base_addr,
    output logic [BEAT_W-1:0] beat,
    output logic              last_beat,
    output logic [ADDR_W-1:0] beat_addr
);

    localparam int BEAT_BYTES = BUS_W / 8;

    // Beat count
    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= '0;
        end else if (start) begin
            beat <= '0;
        end else if (beat_valid) begin
            beat <= beat + 1'b1;
        end
    end

    // Address of the beat being read
    always_ff @(posedge clk) begin
        if (start) begin
            beat_addr <= base_addr;
        end else if (beat_valid) begin
            beat_addr <= beat_addr + ADDR_W'(BEAT_BYTES);
        end
    end

    assign last_beat = (beat == BEAT_W'(FILL_BEATS - 1));

endmodule

// ==== design/cache_array.sv ====
`timescale 1ns/1ps

module cache_array
    import icache_pkg::*;
#(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] rd_index,
    input  logic               wr_en,
    input  logic [INDEX_W-1:0] wr_index,
    input  entry_t             wr_data,
    output entry_t             rd_data
);

    entry_t mem [DEPTH];

    // Reset zeroes every entry
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_index];
    end

endmodule

// ==== design/icache_pkg.sv ====
package icache_pkg;

    // Address and array geometry
    localparam int ADDR_W   = 32;
    localparam int TAG_W    = 23;
    localparam int INDEX_W  = 5;
    localparam int NUM_SETS = 32;

    // Line and bus widths
    localparam int LINE_W     = 128;
    localparam int BUS_W      = 32;
    localparam int FILL_BEATS = LINE_W / BUS_W;
    localparam int BEAT_W     = $clog2(FILL_BEATS);

    // One tag array entry, all zero means invalid
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef logic [LINE_W-1:0] line_t;

    // Request state held from acceptance to response
    typedef struct packed {
        logic [ADDR_W-1:0]  base;
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
        logic               uncacheable;
    } fill_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WAIT_BUS,
        FILL,
        RESPOND
    } ic_state_t;

endpackage
